// File: verilog/dcache_pkg.sv
// Data cache shared widths, tag entry layout and controller state encoding
`default_nettype none

package dcache_pkg;

  localparam int DCACHE_ADDR_WIDTH     = 32;
  localparam int DCACHE_DATA_WIDTH     = 32;
  localparam int DCACHE_LINE_WIDTH     = 128;  // Four words per line
  localparam int DCACHE_OFFSET_BITS    = 4;
  localparam int DCACHE_TAG_FIELD_BITS = 28;   // Covers the smallest index width

  // Tag entry as stored in the tag array
  typedef struct packed {
    logic                             dirty;
    logic [DCACHE_TAG_FIELD_BITS-1:0] tag;  // Only the low tag bits are meaningful
  } dcache_tag_s;

  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,
    STORE,
    WRB,
    REFILL,
    FLUSH_RD,
    FLUSH_CHK,
    FLUSH_WRB
  } dcache_state_e;

endpackage

`default_nettype wire

// File: verilog/dcache_ram.sv
// Single-port cache storage array with registered write-first read
`timescale 1ns/1ps
`default_nettype none

module dcache_ram #(
  parameter type ENTRY_T  = logic [7:0],
  parameter int  IDX_BITS = 4
) (
  input  wire                clk,
  input  wire                rst_n,
  input  wire                req_i,
  input  wire                we_i,
  input  wire [IDX_BITS-1:0] addr_i,
  input  wire ENTRY_T        wdata_i,
  output ENTRY_T             rdata_o
);

  localparam int DEPTH = 2 ** IDX_BITS;

  ENTRY_T mem [DEPTH];

  always_ff @(posedge clk) begin
    if (req_i) begin
      if (we_i) begin
        mem[addr_i] <= wdata_i;
        rdata_o     <= wdata_i;  // Write-first, new entry visible next cycle
      end else begin
        rdata_o <= mem[addr_i];
      end
    end
  end

  // A write always comes with an access
  assert property (@(posedge clk) disable iff (!rst_n) we_i |-> req_i)
    else $error("dcache_ram: write without request");

endmodule

`default_nettype wire

// File: verilog/dcache_flush_counter.sv
// Flush index sweep counter with a flag on the highest index
`timescale 1ns/1ps
`default_nettype none

module dcache_flush_counter #(
  parameter int IDX_BITS = 4
) (
  input  wire                 clk,
  input  wire                 rst_n,
  input  wire                 clr_i,
  input  wire                 step_i,
  output logic [IDX_BITS-1:0] idx_o,
  output logic                last_o
);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      idx_o <= '0;
    end else if (clr_i) begin
      idx_o <= '0;
    end else if (step_i) begin
      idx_o <= idx_o + 1'b1;
    end
  end

  assign last_o = &idx_o;  // All ones is the last line

  // Controller never clears and steps together
  assert property (@(posedge clk) disable iff (!rst_n) !(clr_i && step_i))
    else $error("dcache_flush_counter: clear and step in one cycle");

endmodule

`default_nettype wire

// File: verilog/dcache_datapath.sv
// Data cache datapath with tag compare, byte merge, memory address select and arrays
`timescale 1ns/1ps
`default_nettype none

module dcache_datapath #(
  parameter int IDX_BITS = 4
) (
  input  wire                                      clk,
  input  wire                                      rst_n,
  input  wire                                      rd_en_i,
  input  wire                                      line_wr_i,
  input  wire                                      store_wr_i,
  input  wire                                      clean_wr_i,
  input  wire                                      wrb_sel_i,
  input  wire                                      flush_mode_i,
  input  wire  [IDX_BITS-1:0]                      flush_idx_i,
  input  wire  [dcache_pkg::DCACHE_ADDR_WIDTH-1:0] addr_i,
  input  wire  [dcache_pkg::DCACHE_DATA_WIDTH-1:0] wdata_i,
  input  wire  [3:0]                               sel_byte_i,
  input  wire  [dcache_pkg::DCACHE_LINE_WIDTH-1:0] mem_rdata_i,
  output logic                                     hit_o,
  output logic                                     dirty_valid_o,
  output logic [dcache_pkg::DCACHE_DATA_WIDTH-1:0] rdata_o,
  output logic [dcache_pkg::DCACHE_ADDR_WIDTH-1:0] mem_addr_o,
  output logic [dcache_pkg::DCACHE_LINE_WIDTH-1:0] mem_wdata_o
);

  localparam int OFF_BITS = dcache_pkg::DCACHE_OFFSET_BITS;
  localparam int TAG_BITS = dcache_pkg::DCACHE_ADDR_WIDTH - IDX_BITS - OFF_BITS;
  localparam int WORD_W   = dcache_pkg::DCACHE_DATA_WIDTH;

  logic [TAG_BITS-1:0]                      addr_tag;
  logic [IDX_BITS-1:0]                      addr_idx;
  logic [IDX_BITS-1:0]                      idx;
  logic [1:0]                               word_off;
  logic [dcache_pkg::DCACHE_LINE_WIDTH-1:0] data_rd;
  logic [dcache_pkg::DCACHE_LINE_WIDTH-1:0] data_wr;
  logic [dcache_pkg::DCACHE_LINE_WIDTH-1:0] store_line;
  dcache_pkg::dcache_tag_s                  tag_rd;
  dcache_pkg::dcache_tag_s                  tag_wr;
  logic [2**IDX_BITS-1:0]                   valid_q;
  logic                                     arr_req;
  logic                                     data_we;
  logic                                     tag_we;

  assign addr_tag = addr_i[dcache_pkg::DCACHE_ADDR_WIDTH-1:OFF_BITS+IDX_BITS];
  assign addr_idx = addr_i[OFF_BITS+IDX_BITS-1:OFF_BITS];
  assign word_off = addr_i[OFF_BITS-1:2];
  assign idx      = flush_mode_i ? flush_idx_i : addr_idx;

  // Valid bits kept in flops so reset empties the cache
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= '0;
    end else if (line_wr_i) begin
      valid_q[idx] <= 1'b1;
    end
  end

  assign hit_o         = valid_q[idx] && (tag_rd.tag[TAG_BITS-1:0] == addr_tag);
  assign dirty_valid_o = valid_q[idx] && tag_rd.dirty;

  assign rdata_o = data_rd[word_off*WORD_W +: WORD_W];

  // Replace enabled bytes of the addressed word
  always_comb begin
    store_line = data_rd;
    for (int b = 0; b < 4; b++) begin
      if (sel_byte_i[b]) begin
        store_line[word_off*WORD_W + b*8 +: 8] = wdata_i[b*8 +: 8];
      end
    end
  end

  // Tag entry to write, refill takes the request tag
  always_comb begin
    tag_wr       = tag_rd;
    tag_wr.dirty = store_wr_i;
    if (line_wr_i) begin
      tag_wr.tag                 = '0;
      tag_wr.tag[TAG_BITS-1:0]   = addr_tag;
    end
  end

  assign data_wr = line_wr_i ? mem_rdata_i : store_line;
  assign data_we = line_wr_i | store_wr_i;
  assign tag_we  = line_wr_i | store_wr_i | clean_wr_i;
  assign arr_req = rd_en_i | tag_we;

  // Victim address for writeback, else the requested line
  assign mem_addr_o  = wrb_sel_i ? {tag_rd.tag[TAG_BITS-1:0], idx, {OFF_BITS{1'b0}}}
                                 : {addr_i[dcache_pkg::DCACHE_ADDR_WIDTH-1:OFF_BITS],
                                    {OFF_BITS{1'b0}}};
  assign mem_wdata_o = data_rd;

  dcache_ram #(
    .ENTRY_T  (logic [dcache_pkg::DCACHE_LINE_WIDTH-1:0]),
    .IDX_BITS (IDX_BITS)
  ) i_data_ram (
    .clk     (clk),
    .rst_n   (rst_n),
    .req_i   (arr_req),
    .we_i    (data_we),
    .addr_i  (idx),
    .wdata_i (data_wr),
    .rdata_o (data_rd)
  );

  dcache_ram #(
    .ENTRY_T  (dcache_pkg::dcache_tag_s),
    .IDX_BITS (IDX_BITS)
  ) i_tag_ram (
    .clk     (clk),
    .rst_n   (rst_n),
    .req_i   (arr_req),
    .we_i    (tag_we),
    .addr_i  (idx),
    .wdata_i (tag_wr),
    .rdata_o (tag_rd)
  );

  // Controller issues one kind of array write at a time
  assert property (@(posedge clk) disable iff (!rst_n)
                   $onehot0({line_wr_i, store_wr_i, clean_wr_i}))
    else $error("dcache_datapath: overlapping array writes");

endmodule

`default_nettype wire

// File: verilog/dcache_ctrl.sv
// Data cache controller FSM for lookup, store, writeback, refill and flush sweep
`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl (
  input  wire  clk,
  input  wire  rst_n,
  input  wire  req_i,
  input  wire  wr_i,
  input  wire  flush_i,
  input  wire  hit_i,
  input  wire  dirty_valid_i,
  input  wire  mem_ack_i,
  input  wire  cnt_last_i,
  output logic rd_en_o,
  output logic line_wr_o,
  output logic store_wr_o,
  output logic clean_wr_o,
  output logic wrb_sel_o,
  output logic flush_mode_o,
  output logic cnt_clr_o,
  output logic cnt_step_o,
  output logic mem_req_o,
  output logic mem_wr_o,
  output logic ack_o,
  output logic flush_done_o
);

  dcache_pkg::dcache_state_e state_q, state_d;
  logic                      ack_d;
  logic                      done_d;

  always_comb begin
    state_d      = state_q;
    ack_d        = 1'b0;
    done_d       = 1'b0;
    rd_en_o      = 1'b0;
    line_wr_o    = 1'b0;
    store_wr_o   = 1'b0;
    clean_wr_o   = 1'b0;
    wrb_sel_o    = 1'b0;
    flush_mode_o = 1'b0;
    cnt_clr_o    = 1'b0;
    cnt_step_o   = 1'b0;
    mem_req_o    = 1'b0;
    mem_wr_o     = 1'b0;
    case (state_q)
      dcache_pkg::IDLE: begin
        if (flush_i) begin
          cnt_clr_o = 1'b1;
          state_d   = dcache_pkg::FLUSH_RD;
        end else if (req_i && !ack_o) begin  // Request still high in its ack cycle
          rd_en_o = 1'b1;
          state_d = dcache_pkg::LOOKUP;
        end
      end
      dcache_pkg::LOOKUP: begin
        if (hit_i) begin
          if (wr_i) begin
            state_d = dcache_pkg::STORE;
          end else begin
            ack_d   = 1'b1;
            state_d = dcache_pkg::IDLE;
          end
        end else if (dirty_valid_i) begin
          state_d = dcache_pkg::WRB;
        end else begin
          state_d = dcache_pkg::REFILL;
        end
      end
      dcache_pkg::STORE: begin
        store_wr_o = 1'b1;
        ack_d      = 1'b1;
        state_d    = dcache_pkg::IDLE;
      end
      dcache_pkg::WRB: begin
        mem_req_o = 1'b1;
        mem_wr_o  = 1'b1;
        wrb_sel_o = 1'b1;
        if (mem_ack_i) begin
          clean_wr_o = 1'b1;
          state_d    = dcache_pkg::LOOKUP;  // Misses again, now clean
        end
      end
      dcache_pkg::REFILL: begin
        mem_req_o = 1'b1;
        if (mem_ack_i) begin
          line_wr_o = 1'b1;
          state_d   = dcache_pkg::LOOKUP;
        end
      end
      dcache_pkg::FLUSH_RD: begin
        flush_mode_o = 1'b1;
        rd_en_o      = 1'b1;
        state_d      = dcache_pkg::FLUSH_CHK;
      end
      dcache_pkg::FLUSH_CHK: begin
        flush_mode_o = 1'b1;
        if (dirty_valid_i) begin
          state_d = dcache_pkg::FLUSH_WRB;
        end else if (cnt_last_i) begin
          done_d  = 1'b1;
          state_d = dcache_pkg::IDLE;
        end else begin
          cnt_step_o = 1'b1;
          state_d    = dcache_pkg::FLUSH_RD;
        end
      end
      dcache_pkg::FLUSH_WRB: begin
        flush_mode_o = 1'b1;
        mem_req_o    = 1'b1;
        mem_wr_o     = 1'b1;
        wrb_sel_o    = 1'b1;
        if (mem_ack_i) begin
          clean_wr_o = 1'b1;  // Line stays valid
          if (cnt_last_i) begin
            done_d  = 1'b1;
            state_d = dcache_pkg::IDLE;
          end else begin
            cnt_step_o = 1'b1;
            state_d    = dcache_pkg::FLUSH_RD;
          end
        end
      end
      default: state_d = dcache_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q      <= dcache_pkg::IDLE;
      ack_o        <= 1'b0;
      flush_done_o <= 1'b0;
    end else begin
      state_q      <= state_d;
      ack_o        <= ack_d;   // Registered pulses
      flush_done_o <= done_d;
    end
  end

  // Memory request is held until the memory answers
  assert property (@(posedge clk) disable iff (!rst_n)
                   mem_req_o && !mem_ack_i |=> mem_req_o)
    else $error("dcache_ctrl: memory request dropped before ack");

endmodule

`default_nettype wire

// File: verilog/dcache_top.sv
// Write-back direct-mapped data cache top joining controller, flush counter and datapath
`timescale 1ns/1ps
`default_nettype none

module dcache_top #(
  parameter int IDX_BITS = 4
) (
  input  wire                                      clk,
  input  wire                                      rst_n,
  input  wire                                      req_i,
  input  wire                                      wr_i,
  input  wire  [dcache_pkg::DCACHE_ADDR_WIDTH-1:0] addr_i,
  input  wire  [dcache_pkg::DCACHE_DATA_WIDTH-1:0] wdata_i,
  input  wire  [3:0]                               sel_byte_i,
  input  wire                                      flush_i,
  output logic [dcache_pkg::DCACHE_DATA_WIDTH-1:0] rdata_o,
  output logic                                     ack_o,
  output logic                                     flush_done_o,
  output logic                                     mem_req_o,
  output logic                                     mem_wr_o,
  output logic [dcache_pkg::DCACHE_ADDR_WIDTH-1:0] mem_addr_o,
  output logic [dcache_pkg::DCACHE_LINE_WIDTH-1:0] mem_wdata_o,
  input  wire  [dcache_pkg::DCACHE_LINE_WIDTH-1:0] mem_rdata_i,
  input  wire                                      mem_ack_i
);

  logic                rd_en;
  logic                line_wr;
  logic                store_wr;
  logic                clean_wr;
  logic                wrb_sel;
  logic                flush_mode;
  logic                hit;
  logic                dirty_valid;
  logic                cnt_clr;
  logic                cnt_step;
  logic                cnt_last;
  logic [IDX_BITS-1:0] flush_idx;

  dcache_ctrl i_ctrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .req_i         (req_i),
    .wr_i          (wr_i),
    .flush_i       (flush_i),
    .hit_i         (hit),
    .dirty_valid_i (dirty_valid),
    .mem_ack_i     (mem_ack_i),
    .cnt_last_i    (cnt_last),
    .rd_en_o       (rd_en),
    .line_wr_o     (line_wr),
    .store_wr_o    (store_wr),
    .clean_wr_o    (clean_wr),
    .wrb_sel_o     (wrb_sel),
    .flush_mode_o  (flush_mode),
    .cnt_clr_o     (cnt_clr),
    .cnt_step_o    (cnt_step),
    .mem_req_o     (mem_req_o),
    .mem_wr_o      (mem_wr_o),
    .ack_o         (ack_o),
    .flush_done_o  (flush_done_o)
  );

  dcache_flush_counter #(
    .IDX_BITS (IDX_BITS)
  ) i_flush_counter (
    .clk    (clk),
    .rst_n  (rst_n),
    .clr_i  (cnt_clr),
    .step_i (cnt_step),
    .idx_o  (flush_idx),
    .last_o (cnt_last)
  );

  dcache_datapath #(
    .IDX_BITS (IDX_BITS)
  ) i_datapath (
    .clk           (clk),
    .rst_n         (rst_n),
    .rd_en_i       (rd_en),
    .line_wr_i     (line_wr),
    .store_wr_i    (store_wr),
    .clean_wr_i    (clean_wr),
    .wrb_sel_i     (wrb_sel),
    .flush_mode_i  (flush_mode),
    .flush_idx_i   (flush_idx),
    .addr_i        (addr_i),
    .wdata_i       (wdata_i),
    .sel_byte_i    (sel_byte_i),
    .mem_rdata_i   (mem_rdata_i),
    .hit_o         (hit),
    .dirty_valid_o (dirty_valid),
    .rdata_o       (rdata_o),
    .mem_addr_o    (mem_addr_o),
    .mem_wdata_o   (mem_wdata_o)
  );

endmodule

`default_nettype wire

// File: tb/dcache_mem_model.sv
// Line-wide main memory model with rule-based contents, random ack delay and write count
`timescale 1ns/1ps
`default_nettype none

module dcache_mem_model (
  input  wire          clk,
  input  wire          rst_n,
  input  wire          mem_req_i,
  input  wire          mem_wr_i,
  input  wire  [31:0]  mem_addr_i,
  input  wire  [127:0] mem_wdata_i,
  output logic [127:0] mem_rdata_o,
  output logic         mem_ack_o,
  output logic [31:0]  wr_count_o
);

  localparam int LINES = 1024;  // 16 KiB window

  logic [127:0] lines [LINES];
  logic [9:0]   line_idx;
  logic         busy;
  logic [2:0]   wait_q;
  int           seed;

  assign line_idx = mem_addr_i[13:4];

  // Word at byte address A holds A xor 5a5a_0000
  initial begin
    seed = 32'hccdd_05c0;
    mem_ack_o   <= 1'b0;
    mem_rdata_o <= '0;
    for (int l = 0; l < LINES; l++) begin
      for (int w = 0; w < 4; w++) begin
        lines[l][w*32 +: 32] = (l * 16 + w * 4) ^ 32'h5a5a_0000;
      end
    end
  end

  always @(posedge clk) begin
    if (!rst_n) begin
      mem_ack_o  <= 1'b0;
      busy       <= 1'b0;
      wait_q     <= '0;
      wr_count_o <= '0;
    end else begin
      mem_ack_o <= 1'b0;
      if (mem_ack_o) begin
        busy <= 1'b0;  // Request drops after the ack
      end else if (mem_req_i && !busy) begin
        busy   <= 1'b1;
        wait_q <= 3'({$random(seed)} % 4 + 1);  // 1 to 4 cycles
      end else if (busy) begin
        if (wait_q == 3'd1) begin
          mem_ack_o <= 1'b1;
          if (mem_wr_i) begin
            lines[line_idx] <= mem_wdata_i;
            wr_count_o      <= wr_count_o + 32'd1;
          end else begin
            mem_rdata_o <= lines[line_idx];
          end
        end else begin
          wait_q <= wait_q - 3'd1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: tb/dcache_tb.sv
// Data cache testbench with memory model, reference cache state and operation table
`timescale 1ns/1ps
`default_nettype none

module dcache_tb;

  localparam int IDX_BITS = 4;
  localparam int MAX_ROWS = 256;
  localparam int TIMEOUT  = 500;

  localparam logic [1:0] OP_LD = 2'd0;
  localparam logic [1:0] OP_ST = 2'd1;
  localparam logic [1:0] OP_FL = 2'd2;

  logic         clk;
  logic         rst_n;
  logic         req;
  logic         wr;
  logic [31:0]  addr;
  logic [31:0]  wdata;
  logic [3:0]   sel;
  logic         flush;
  logic [31:0]  rdata;
  logic         ack;
  logic         flush_done;
  logic         mem_req;
  logic         mem_wr;
  logic [31:0]  mem_addr;
  logic [127:0] mem_wdata;
  logic [127:0] mem_rdata;
  logic         mem_ack;
  logic [31:0]  wr_count;

  // Operation table, one entry per row
  logic [1:0]  tab_op    [MAX_ROWS];
  logic [31:0] tab_addr  [MAX_ROWS];
  logic [31:0] tab_wdata [MAX_ROWS];
  logic [3:0]  tab_sel   [MAX_ROWS];
  logic [31:0] tab_exp   [MAX_ROWS];
  logic        tab_hit   [MAX_ROWS];
  int          tab_wrs   [MAX_ROWS];
  int          n_rows;

  // Reference view of memory words and of the cache lines
  logic [31:0] shadow    [4096];
  logic        ref_valid [16];
  logic        ref_dirty [16];
  logic [31:0] ref_tag   [16];
  int          seed;

  dcache_top #(
    .IDX_BITS (IDX_BITS)
  ) i_dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .req_i        (req),
    .wr_i         (wr),
    .addr_i       (addr),
    .wdata_i      (wdata),
    .sel_byte_i   (sel),
    .flush_i      (flush),
    .rdata_o      (rdata),
    .ack_o        (ack),
    .flush_done_o (flush_done),
    .mem_req_o    (mem_req),
    .mem_wr_o     (mem_wr),
    .mem_addr_o   (mem_addr),
    .mem_wdata_o  (mem_wdata),
    .mem_rdata_i  (mem_rdata),
    .mem_ack_i    (mem_ack)
  );

  dcache_mem_model i_mem (
    .clk         (clk),
    .rst_n       (rst_n),
    .mem_req_i   (mem_req),
    .mem_wr_i    (mem_wr),
    .mem_addr_i  (mem_addr),
    .mem_wdata_i (mem_wdata),
    .mem_rdata_o (mem_rdata),
    .mem_ack_o   (mem_ack),
    .wr_count_o  (wr_count)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Done: errors found");
    $fatal(1);
  endtask

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      abort_run($sformatf("ERR %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  // Appends a row and advances the reference state
  task automatic add_row(input logic [1:0] op, input logic [31:0] a,
                         input logic [31:0] d, input logic [3:0] s);
    logic [3:0]  idx;
    logic [31:0] tag;
    logic        hit;
    int          writes;
    idx    = a[7:4];
    tag    = a >> 8;
    hit    = 1'b0;
    writes = 0;
    if (op == OP_FL) begin
      for (int i = 0; i < 16; i++) begin
        if (ref_valid[i] && ref_dirty[i]) begin
          writes++;
          ref_dirty[i] = 1'b0;  // Cleaned, still valid
        end
      end
    end else begin
      hit = ref_valid[idx] && (ref_tag[idx] == tag);
      if (!hit) begin
        if (ref_valid[idx] && ref_dirty[idx]) begin
          writes = 1;  // Victim goes back first
        end
        ref_valid[idx] = 1'b1;
        ref_dirty[idx] = 1'b0;
        ref_tag[idx]   = tag;
      end
      if (op == OP_ST) begin
        for (int b = 0; b < 4; b++) begin
          if (s[b]) begin
            shadow[a[13:2]][b*8 +: 8] = d[b*8 +: 8];
          end
        end
        ref_dirty[idx] = 1'b1;
      end
    end
    tab_op[n_rows]    = op;
    tab_addr[n_rows]  = a;
    tab_wdata[n_rows] = d;
    tab_sel[n_rows]   = s;
    tab_exp[n_rows]   = shadow[a[13:2]];
    tab_hit[n_rows]   = hit;
    tab_wrs[n_rows]   = writes;
    n_rows++;
  endtask

  // Cycles after the request cycle until ack_o
  task automatic wait_ack(input string name, output int lat);
    int n;
    n = 0;
    @(negedge clk);
    while (!ack && n < TIMEOUT) begin
      n++;
      @(negedge clk);
    end
    if (!ack) begin
      abort_run($sformatf("Timeout: ack_o never came for %s", name));
    end
    lat = n;
  endtask

  task automatic wait_flush_done(input string name);
    int n;
    n = 0;
    @(negedge clk);
    while (!flush_done && n < TIMEOUT) begin
      n++;
      @(negedge clk);
    end
    if (!flush_done) begin
      abort_run($sformatf("Timeout: flush_done_o never came for %s", name));
    end
  endtask

  task automatic run_row(input int r);
    string       name;
    int          lat;
    int          hit_lat;
    logic [31:0] wr_before;
    name      = $sformatf("row %0d", r);
    wr_before = wr_count;
    if (tab_op[r] == OP_FL) begin
      @(posedge clk);
      flush <= 1'b1;
      @(posedge clk);
      flush <= 1'b0;
      wait_flush_done(name);
    end else begin
      @(posedge clk);
      req   <= 1'b1;
      wr    <= (tab_op[r] == OP_ST);
      addr  <= tab_addr[r];
      wdata <= tab_wdata[r];
      sel   <= tab_sel[r];
      wait_ack(name, lat);
      hit_lat = (tab_op[r] == OP_ST) ? 3 : 2;
      if (tab_op[r] == OP_LD) begin
        check_val({name, " load data"}, tab_exp[r], rdata);
      end
      if (tab_hit[r]) begin
        check_val({name, " hit latency"}, 32'(hit_lat), 32'(lat));
      end else begin
        check_val({name, " miss slower than hit"}, 32'd1, 32'(lat > hit_lat));
      end
      @(posedge clk);
      req <= 1'b0;  // Dropped in the cycle after ack
    end
    check_val({name, " memory writes"}, 32'(tab_wrs[r]), wr_count - wr_before);
  endtask

  initial begin
    logic [31:0] rnd;
    logic [31:0] rdat;
    logic [31:0] raddr;
    rst_n  = 1'b0;
    req    = 1'b0;
    wr     = 1'b0;
    addr   = '0;
    wdata  = '0;
    sel    = '0;
    flush  = 1'b0;
    seed   = 32'hccdd_05c0;
    n_rows = 0;
    for (int w = 0; w < 4096; w++) begin
      shadow[w] = (w * 4) ^ 32'h5a5a_0000;
    end
    for (int i = 0; i < 16; i++) begin
      ref_valid[i] = 1'b0;
      ref_dirty[i] = 1'b0;
      ref_tag[i]   = '0;
    end

    // Cold misses, hits and partial stores
    add_row(OP_LD, 32'h0000_0040, 32'h0, 4'h0);
    add_row(OP_LD, 32'h0000_0040, 32'h0, 4'h0);
    add_row(OP_ST, 32'h0000_0044, 32'hdead_beef, 4'b0011);
    add_row(OP_LD, 32'h0000_0044, 32'h0, 4'h0);
    add_row(OP_ST, 32'h0000_0048, 32'h1234_5678, 4'b1000);
    add_row(OP_LD, 32'h0000_0048, 32'h0, 4'h0);
    add_row(OP_ST, 32'h0000_0150, 32'hcafe_f00d, 4'b0110);
    add_row(OP_LD, 32'h0000_0150, 32'h0, 4'h0);
    // Conflict on index 4 evicts the dirty line
    add_row(OP_LD, 32'h0000_0340, 32'h0, 4'h0);
    add_row(OP_LD, 32'h0000_0044, 32'h0, 4'h0);
    // Flush, then hits, then an empty flush
    add_row(OP_ST, 32'h0000_0260, 32'h0bad_c0de, 4'b1111);
    add_row(OP_FL, 32'h0, 32'h0, 4'h0);
    add_row(OP_LD, 32'h0000_0044, 32'h0, 4'h0);
    add_row(OP_LD, 32'h0000_0150, 32'h0, 4'h0);
    add_row(OP_LD, 32'h0000_0260, 32'h0, 4'h0);
    add_row(OP_FL, 32'h0, 32'h0, 4'h0);
    // Random mix over two tags, 16 indexes, two words per line
    for (int i = 0; i < 48; i++) begin
      rnd   = $random(seed);
      rdat  = $random(seed);
      raddr = (rnd[0] ? 32'h0000_0600 : 32'h0000_0100) | {24'd0, rnd[4:1], 4'd0}
              | {29'd0, rnd[5], 2'd0};
      add_row(rnd[6] ? OP_ST : OP_LD, raddr, rdat, rnd[10:7]);
    end
    add_row(OP_FL, 32'h0, 32'h0, 4'h0);

    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_val("reset ack_o", 32'd0, 32'(ack));
    check_val("reset flush_done_o", 32'd0, 32'(flush_done));
    check_val("reset mem_req_o", 32'd0, 32'(mem_req));

    for (int r = 0; r < n_rows; r++) begin
      run_row(r);
    end

    $display("Done: no errors");
    $finish;
  end

endmodule

`default_nettype wire

// File: build.f
verilog/dcache_pkg.sv
verilog/dcache_ram.sv
verilog/dcache_flush_counter.sv
verilog/dcache_datapath.sv
verilog/dcache_ctrl.sv
verilog/dcache_top.sv
tb/dcache_mem_model.sv
tb/dcache_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the data cache testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module dcache_tb \
  -Mdir obj_dir \
  -f build.f

./obj_dir/Vdcache_tb | tee sim.log

if grep -q "Done: errors found" sim.log; then
  echo "Simulation FAILED"
  exit 1
fi

echo "Simulation PASSED"
exit 0
